// ==== Bender.yml ====
package:
  name: weight_controller

sources:
  - nn_train_pkg.sv
  - activation_unit.sv
  - cell_counter.sv
  - update_sequencer.sv
  - weight_updater.sv
  - weight_store.sv
  - weight_controller.sv
  - target: test
    files:
      - weight_controller_chk.sv
      - weight_controller_tb.sv

// ==== activation_unit.sv ====
`timescale 1ns/1ps

module activation_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  capture,
    input  nn_train_pkg::z_vec_t  z,
    output nn_train_pkg::act_vec_t a
);

    import nn_train_pkg::*;

    act_vec_t a_next;

    // hard sigmoid per neuron: (z >>> 1) + 128, clamped to 0..256
    for (genvar n = 0; n < neuron_num; n++) begin : g_neuron
        logic signed [z_width-1:0] z_cell;
        logic signed [z_width:0]   biased;  // one bit wider than z
        logic [act_width-1:0]      act;

        assign z_cell = z[n*z_width +: z_width];
        assign biased = (z_cell >>> 1) + (z_width + 1)'(act_offset);

        always_comb begin
            if (biased < 0) begin
                act = '0;
            end else if (biased > act_one) begin
                act = act_width'(act_one);  // saturate at 1.0
            end else begin
                act = biased[act_width-1:0];
            end
        end

        assign a_next[n*act_width +: act_width] = act;
    end

    // held for the whole update phase
    always_ff @(posedge clk) begin
        if (reset) begin
            a <= '0;
        end else if (capture) begin
            a <= a_next;
        end
    end

endmodule

// ==== build.f ====
nn_train_pkg.sv
activation_unit.sv
cell_counter.sv
update_sequencer.sv
weight_updater.sv
weight_store.sv
weight_controller.sv
weight_controller_chk.sv
weight_controller_tb.sv

// ==== cell_counter.sv ====
`timescale 1ns/1ps

module cell_counter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    clear,
    input  logic                    enable,
    output nn_train_pkg::cell_idx_t cell_idx,
    output logic                    last_cell
);

    import nn_train_pkg::*;

    cell_idx_t count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (enable) begin
            count <= count + 1'b1;  // wraps after the last cell
        end
    end

    assign cell_idx = count;

    // final write of the matrix
    assign last_cell = enable && (count == cell_idx_t'(cell_num - 1));

endmodule

// ==== nn_train_pkg.sv ====
package nn_train_pkg;

    //////////////////////////////////////////////////////////////////////
    // network sizes
    //////////////////////////////////////////////////////////////////////

    localparam int neuron_num        = 4;  // neurons per layer
    localparam int layer_num         = 4;
    localparam int cell_num          = neuron_num * neuron_num;
    localparam int neuron_idx_width  = $clog2(neuron_num);
    localparam int cell_idx_width    = 2 * neuron_idx_width;  // row bits above column bits
    localparam int layer_addr_width  = $clog2(layer_num);

    //////////////////////////////////////////////////////////////////////
    // fixed point formats
    //////////////////////////////////////////////////////////////////////

    localparam int z_width             = 10;  // signed
    localparam int act_width           = 9;   // unsigned, 256 is 1.0
    localparam int act_frac_bits       = 8;
    localparam int delta_width         = 10;  // signed
    localparam int weight_width        = 12;  // signed
    localparam int learning_rate_shift = 0;

    localparam int act_one    = 1 << act_frac_bits;
    localparam int act_offset = act_one / 2;  // sigmoid midpoint
    localparam int weight_max = (1 << (weight_width - 1)) - 1;
    localparam int weight_min = -(1 << (weight_width - 1));

    // a[j] * delta[i] and old weight minus step, with headroom
    localparam int prod_width = act_width + 1 + delta_width;
    localparam int diff_width = prod_width + 1;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef logic [layer_addr_width-1:0]         layer_addr_t;
    typedef logic [neuron_num*z_width-1:0]       z_vec_t;
    typedef logic [neuron_num*act_width-1:0]     act_vec_t;
    typedef logic [neuron_num*delta_width-1:0]   delta_vec_t;
    typedef logic signed [weight_width-1:0]      weight_t;
    typedef logic [cell_num*weight_width-1:0]    weight_mat_t;
    typedef logic [cell_idx_width-1:0]           cell_idx_t;

    typedef enum logic [1:0] {
        st_idle,     // waiting for layer, z and delta
        st_present,  // old matrix on w
        st_update    // one cell per cycle
    } seq_state_t;

endpackage

// ==== update_sequencer.sv ====
`timescale 1ns/1ps

module update_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      layer_valid,
    input  logic                      z_valid,
    input  logic                      delta_valid,
    input  logic                      w_ready,
    input  logic                      last_cell,
    input  nn_train_pkg::layer_addr_t layer,
    output logic                      layer_ready,
    output logic                      z_ready,
    output logic                      delta_ready,
    output logic                      w_valid,
    output logic                      capture,
    output logic                      count_clear,
    output logic                      count_enable,
    output logic                      write_enable,
    output nn_train_pkg::layer_addr_t cur_layer
);

    import nn_train_pkg::*;

    seq_state_t state;
    seq_state_t state_next;
    logic       all_valid;
    logic       accept;

    //////////////////////////////////////////////////////////////////////
    // handshakes
    //////////////////////////////////////////////////////////////////////

    assign all_valid = layer_valid && z_valid && delta_valid;
    assign accept    = (state == st_idle) && all_valid;  // joint transfer

    assign layer_ready = accept;
    assign z_ready     = accept;
    assign delta_ready = accept;
    assign capture     = accept;

    assign w_valid      = (state == st_present);
    assign count_clear  = w_valid && w_ready;  // w transfer starts the update
    assign count_enable = (state == st_update);
    assign write_enable = count_enable;

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            st_idle:    if (accept) state_next = st_present;
            st_present: if (w_ready) state_next = st_update;  // waits on back-pressure
            st_update:  if (last_cell) state_next = st_idle;
            default:    state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            cur_layer <= '0;
        end else begin
            state <= state_next;
            if (accept) begin
                cur_layer <= layer;
            end
        end
    end

endmodule

// ==== weight_controller.sv ====
`timescale 1ns/1ps

module weight_controller (
    input  logic                      clk,
    input  logic                      reset,
    // layer
    input  nn_train_pkg::layer_addr_t layer,
    input  logic                      layer_valid,
    output logic                      layer_ready,
    // z
    input  nn_train_pkg::z_vec_t      z,
    input  logic                      z_valid,
    output logic                      z_ready,
    // delta
    input  nn_train_pkg::delta_vec_t  delta,
    input  logic                      delta_valid,
    output logic                      delta_ready,
    // w
    output nn_train_pkg::weight_mat_t w,
    output logic                      w_valid,
    input  logic                      w_ready,
    // saturation seen
    output logic                      error
);

    import nn_train_pkg::*;

    logic        capture;
    logic        count_clear;
    logic        count_enable;
    logic        write_enable;
    logic        last_cell;
    layer_addr_t cur_layer;
    cell_idx_t   cell_idx;
    act_vec_t    a;
    weight_t     new_weight;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    update_sequencer i_update_sequencer (
        .clk          (clk),
        .reset        (reset),
        .layer_valid  (layer_valid),
        .z_valid      (z_valid),
        .delta_valid  (delta_valid),
        .w_ready      (w_ready),
        .last_cell    (last_cell),
        .layer        (layer),
        .layer_ready  (layer_ready),
        .z_ready      (z_ready),
        .delta_ready  (delta_ready),
        .w_valid      (w_valid),
        .capture      (capture),
        .count_clear  (count_clear),
        .count_enable (count_enable),
        .write_enable (write_enable),
        .cur_layer    (cur_layer)
    );

    cell_counter i_cell_counter (
        .clk       (clk),
        .reset     (reset),
        .clear     (count_clear),
        .enable    (count_enable),
        .cell_idx  (cell_idx),
        .last_cell (last_cell)
    );

    //////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////

    activation_unit i_activation_unit (
        .clk     (clk),
        .reset   (reset),
        .capture (capture),
        .z       (z),
        .a       (a)
    );

    weight_updater i_weight_updater (
        .clk          (clk),
        .reset        (reset),
        .capture      (capture),
        .write_enable (write_enable),
        .delta        (delta),
        .a            (a),
        .cell_idx     (cell_idx),
        .old_weights  (w),  // same matrix that is presented
        .new_weight   (new_weight),
        .error        (error)
    );

    weight_store i_weight_store (
        .clk          (clk),
        .reset        (reset),
        .write_enable (write_enable),
        .layer        (cur_layer),
        .cell_idx     (cell_idx),
        .new_weight   (new_weight),
        .weights      (w)
    );

endmodule

// ==== weight_controller_chk.sv ====
`timescale 1ns/1ps

module weight_controller_chk (
    input logic                      clk,
    input logic                      reset,
    input logic                      layer_valid,
    input logic                      z_valid,
    input logic                      delta_valid,
    input logic                      layer_ready,
    input logic                      z_ready,
    input logic                      delta_ready,
    input nn_train_pkg::weight_mat_t w,
    input logic                      w_valid,
    input logic                      w_ready,
    input logic                      error
);

    int fail_count = 0;  // read by the testbench

    // the three inputs transfer together or not at all
    joint_ready: assert property (@(posedge clk) disable iff (reset)
        (layer_ready == z_ready) && (z_ready == delta_ready)
        && (!layer_ready || (layer_valid && z_valid && delta_valid)))
    else begin
        $error("input readies differ or rose without all three valids");
        fail_count++;
    end

    w_hold: assert property (@(posedge clk) disable iff (reset)
        w_valid && !w_ready |=> w_valid && $stable(w))
    else begin
        $error("w_valid or w changed before the w transfer");
        fail_count++;
    end

    error_sticky: assert property (@(posedge clk) disable iff (reset) error |=> error)
    else begin
        $error("error fell outside reset");
        fail_count++;
    end

endmodule

bind weight_controller weight_controller_chk i_weight_controller_chk (
    .clk         (clk),
    .reset       (reset),
    .layer_valid (layer_valid),
    .z_valid     (z_valid),
    .delta_valid (delta_valid),
    .layer_ready (layer_ready),
    .z_ready     (z_ready),
    .delta_ready (delta_ready),
    .w           (w),
    .w_valid     (w_valid),
    .w_ready     (w_ready),
    .error       (error)
);

// ==== weight_controller_tb.sv ====
`timescale 1ns/1ps

module weight_controller_tb;

    import nn_train_pkg::*;

    localparam int clk_period    = 8;
    localparam int cycles_per_tx = 40;  // watchdog budget per trace line

    logic        clk;
    logic        reset;
    layer_addr_t layer;
    logic        layer_valid;
    logic        layer_ready;
    z_vec_t      z;
    logic        z_valid;
    logic        z_ready;
    delta_vec_t  delta;
    logic        delta_valid;
    logic        delta_ready;
    weight_mat_t w;
    logic        w_valid;
    logic        w_ready;
    logic        error;

    // one entry per trace line
    layer_addr_t tr_layer[$];
    z_vec_t      tr_z[$];
    delta_vec_t  tr_delta[$];
    weight_mat_t tr_w[$];
    logic        tr_error[$];

    int unsigned cycle = 0;
    int unsigned accept_cycle;
    int unsigned wx_cycle;  // cycle count just before the w transfer
    int          err_count = 0;
    int          check_count = 0;
    bit          trace_loaded = 1'b0;

    weight_controller i_weight_controller (
        .clk         (clk),
        .reset       (reset),
        .layer       (layer),
        .layer_valid (layer_valid),
        .layer_ready (layer_ready),
        .z           (z),
        .z_valid     (z_valid),
        .z_ready     (z_ready),
        .delta       (delta),
        .delta_valid (delta_valid),
        .delta_ready (delta_ready),
        .w           (w),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .error       (error)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic compare_bit(input string name, input logic got, input logic exp);
        check_count++;
        assert (got === exp) else begin
            $display("MISMATCH %0t %s expected %0b got %0b", $time, name, exp, got);
            err_count++;
        end
    endtask

    task automatic check_w(input weight_mat_t exp_w);
        check_count++;
        assert (w === exp_w) else begin
            $display("MISMATCH %0t w expected %h got %h", $time, exp_w, w);
            err_count++;
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        check_count++;
        assert (cond) else begin
            $display("ERROR %0t %s", $time, what);
            err_count++;
        end
    endtask

    function automatic int total_errors();
        return err_count + i_weight_controller.i_weight_controller_chk.fail_count;
    endfunction

    task automatic print_counts();
        $display("checks %0d, errors %0d, assertion failures %0d", check_count,
                 err_count, i_weight_controller.i_weight_controller_chk.fail_count);
    endtask

    //////////////////////////////////////////////////////////////////////
    // trace and handshakes
    //////////////////////////////////////////////////////////////////////

    task automatic load_trace();
        int          fd;
        string       text;
        layer_addr_t l;
        z_vec_t      zv;
        delta_vec_t  dv;
        weight_mat_t wv;
        logic        ev;
        fd = $fopen("weight_trace.txt", "r");
        expect_true(fd != 0, "could not open weight_trace.txt");
        if (fd == 0) return;
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            if (text.len() < 2 || text.substr(0, 1) == "//") continue;  // comments, blanks
            if ($sscanf(text, "%h %h %h %h %h", l, zv, dv, wv, ev) == 5) begin
                tr_layer.push_back(l);
                tr_z.push_back(zv);
                tr_delta.push_back(dv);
                tr_w.push_back(wv);
                tr_error.push_back(ev);
            end
        end
        $fclose(fd);
        expect_true(tr_layer.size() > 0, "the trace holds no transaction");
    endtask

    // starts and ends on a falling edge
    task automatic send_inputs(input int k);
        int early;
        early = $urandom_range(6, 1);  // one or two valids lead
        repeat ($urandom_range(3, 0)) @(negedge clk);
        layer       = tr_layer[k];
        z           = tr_z[k];
        delta       = tr_delta[k];
        layer_valid = early[0];
        z_valid     = early[1];
        delta_valid = early[2];
        repeat ($urandom_range(2, 1)) begin
            #1;
            expect_true(!layer_ready && !z_ready && !delta_ready,
                        "an input was ready before all three valids were high");
            @(negedge clk);
        end
        layer_valid = 1'b1;
        z_valid     = 1'b1;
        delta_valid = 1'b1;
        #1;
        while (layer_ready !== 1'b1) begin
            @(negedge clk);
            #1;
        end
        accept_cycle = cycle;
        expect_true(z_ready && delta_ready, "z_ready or delta_ready missed the joint transfer");
        @(negedge clk);
        layer_valid = 1'b0;
        z_valid     = 1'b0;
        delta_valid = 1'b0;
    endtask

    task automatic take_w(input int k);
        weight_mat_t held;
        while (w_valid !== 1'b1) @(negedge clk);
        expect_true(cycle == accept_cycle + 1, "w_valid was not high one cycle after input");
        check_w(tr_w[k]);
        held = w;
        repeat ($urandom_range(4, 0)) begin  // back-pressure
            @(negedge clk);
            expect_true(w_valid === 1'b1 && w === held, "w_valid or w changed before w_ready");
        end
        w_ready  = 1'b1;
        wx_cycle = cycle;
        @(negedge clk);
        w_ready = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h12cf));
        reset       = 1'b1;
        layer       = '0;
        layer_valid = 1'b0;
        z           = '0;
        z_valid     = 1'b0;
        delta       = '0;
        delta_valid = 1'b0;
        w_ready     = 1'b0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        compare_bit("layer_ready", layer_ready, 1'b0);
        compare_bit("z_ready", z_ready, 1'b0);
        compare_bit("delta_ready", delta_ready, 1'b0);
        compare_bit("w_valid", w_valid, 1'b0);
        compare_bit("error", error, 1'b0);
        if (tr_layer.size() > 0) begin
            send_inputs(0);
        end
        for (int k = 0; k < tr_layer.size(); k++) begin
            fork
                take_w(k);
                // next inputs wait through the w wait and the update
                if (k + 1 < tr_layer.size()) send_inputs(k + 1);
            join
            if (k + 1 < tr_layer.size()) begin
                expect_true(accept_cycle == wx_cycle + cell_num + 1,
                            "next input was not accepted one cycle after the last write");
                compare_bit("error", error, tr_error[k]);  // update k done
            end
        end
        repeat (cell_num + 1) @(negedge clk);  // last update runs out
        if (tr_layer.size() > 0) compare_bit("error", error, tr_error[tr_layer.size()-1]);
        print_counts();
        if (total_errors() == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        wait (trace_loaded);
        repeat (tr_layer.size() * cycles_per_tx) @(posedge clk);
        $display("timeout: the trace did not finish within %0d cycles",
                 tr_layer.size() * cycles_per_tx);
        print_counts();
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== weight_store.sv ====
`timescale 1ns/1ps

module weight_store (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      write_enable,
    input  nn_train_pkg::layer_addr_t layer,
    input  nn_train_pkg::cell_idx_t   cell_idx,
    input  nn_train_pkg::weight_t     new_weight,
    output nn_train_pkg::weight_mat_t weights
);

    import nn_train_pkg::*;

    weight_mat_t mem [layer_num];  // one full matrix per layer

    //////////////////////////////////////////////////////////////////////
    // single cell write
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int l = 0; l < layer_num; l++) begin
                mem[l] <= '0;
            end
        end else if (write_enable) begin
            mem[layer][cell_idx*weight_width +: weight_width] <= new_weight;
        end
    end

    // whole matrix of the addressed layer, no read latency
    assign weights = mem[layer];

endmodule

// ==== weight_trace.txt ====
// hex columns: layer z(4x10b) delta(4x10b) expected_w(16x12b, cell 15 first) error_after
// expected_w is the matrix read before this line's update
0 4010040100 0100300801 000000000000000000000000000000000000000000000000 0
1 400007FE00 F03E0FC3F8 000000000000000000000000000000000000000000000000 0
0 400007FE00 0100300801 FFCFFCFFCFFCFFDFFDFFDFFDFFEFFEFFEFFEFFFFFFFFFFFF 0
2 4010040100 F03E0FC3F8 000000000000000000000000000000000000000000000000 0
1 4010040100 0100300801 040020040000020010020000010008010000008004008000 0
3 4010040100 0100300801 000000000000000000000000000000000000000000000000 0
0 4010040100 F03E0FC3F8 FF8FFAFF8FFCFFAFFCFFAFFDFFCFFDFFCFFEFFEFFFFFEFFF 0
2 400007FE00 0100300801 040040040040020020020020010010010010008008008008 0
1 400007FE00 F03E0FC3F8 03C01C03CFFC01D00D01DFFD00E00600EFFE007003007FFF 0
3 4010040100 8020080200 FFCFFCFFCFFCFFDFFDFFDFFDFFEFFEFFEFFEFFFFFFFFFFFF 0
3 4010040100 8020080200 1FC1FC1FC1FC1FD1FD1FD1FD1FE1FE1FE1FE1FF1FF1FF1FF 0
3 4010040100 8020080200 3FC3FC3FC3FC3FD3FD3FD3FD3FE3FE3FE3FE3FF3FF3FF3FF 0
3 4010040100 8020080200 5FC5FC5FC5FC5FD5FD5FD5FD5FE5FE5FE5FE5FF5FF5FF5FF 0
3 4010040100 8020080200 7FC7FC7FC7FC7FD7FD7FD7FD7FE7FE7FE7FE7FF7FF7FF7FF 1
3 400007FE00 7FDFF7FDFF 7FF7FF7FF7FF7FF7FF7FF7FF7FF7FF7FF7FF7FF7FF7FF7FF 1
2 4010040100 7FDFF7FDFF 03C03E03C04001D01F01D02000E00F00E010007008007008 1
2 4010040100 7FDFF7FDFF E3DE3FE3DE41E1EE20E1EE21E0FE10E0FE11E08E09E08E09 1
2 4010040100 7FDFF7FDFF C3EC40C3EC42C1FC21C1FC22C10C11C10C12C09C0AC09C0A 1
2 4010040100 7FDFF7FDFF A3FA41A3FA43A20A22A20A23A11A12A11A13A0AA0BA0AA0B 1
2 4010040100 7FDFF7FDFF 84084284084482182382182481281381281480B80C80B80C 1
2 4010040100 0100300801 800800800800800800800800800800800800800800800800 1
3 4010040100 0100300801 6007006007FF6007006007FF6007006007FF6007006007FF 1

// ==== weight_updater.sv ====
`timescale 1ns/1ps

module weight_updater (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      capture,
    input  logic                      write_enable,
    input  nn_train_pkg::delta_vec_t  delta,
    input  nn_train_pkg::act_vec_t    a,
    input  nn_train_pkg::cell_idx_t   cell_idx,
    input  nn_train_pkg::weight_mat_t old_weights,
    output nn_train_pkg::weight_t     new_weight,
    output logic                      error
);

    import nn_train_pkg::*;

    delta_vec_t                    delta_q;
    logic [neuron_idx_width-1:0]   row;
    logic [neuron_idx_width-1:0]   col;
    logic signed [delta_width-1:0] delta_cell;
    logic [act_width-1:0]          act_cell;
    weight_t                       old_cell;
    logic signed [prod_width-1:0]  product;
    logic signed [prod_width-1:0]  step;
    logic signed [diff_width-1:0]  diff;
    logic                          saturated;

    always_ff @(posedge clk) begin
        if (capture) begin
            delta_q <= delta;
        end
    end

    assign row = cell_idx[cell_idx_width-1:neuron_idx_width];  // i
    assign col = cell_idx[neuron_idx_width-1:0];               // j

    //////////////////////////////////////////////////////////////////////
    // w[i][j] - ((a[j] * delta[i]) >>> shift), saturated
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        delta_cell = delta_q[row*delta_width +: delta_width];
        act_cell   = a[col*act_width +: act_width];
        old_cell   = old_weights[cell_idx*weight_width +: weight_width];

        product = $signed({1'b0, act_cell}) * delta_cell;  // activation is unsigned
        step    = product >>> (act_frac_bits + learning_rate_shift);
        diff    = old_cell - step;

        saturated = 1'b1;
        if (diff > weight_max) begin
            new_weight = weight_t'(weight_max);
        end else if (diff < weight_min) begin
            new_weight = weight_t'(weight_min);
        end else begin
            new_weight = diff[weight_width-1:0];
            saturated  = 1'b0;
        end
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            error <= 1'b0;
        end else if (write_enable && saturated) begin
            error <= 1'b1;
        end
    end

endmodule
